/* rtl/spinn_link_pkg.sv */
// shared constants, code table and packet word type for the spinnaker link node, imported by rtl
package spinn_link_pkg;

  // --------------------------------------------------------------------------
  // packet format
  // --------------------------------------------------------------------------
  localparam int pkt_bits = 72;             // long packet, short uses low 40

  localparam logic [4:0] short_syms = 5'd10; // data nibbles, short packet
  localparam logic [4:0] long_syms  = 5'd18; // data nibbles, long packet

  localparam int long_bit = 1;              // long flag position in ctrl byte

  localparam int count_bits = 16;           // packet counter width

  // --------------------------------------------------------------------------
  // nrz 2-of-7 symbols
  // --------------------------------------------------------------------------
  // each code flips exactly two of the seven wires
  localparam logic [6:0] code_2of7 [16] = '{
    7'h11, 7'h12, 7'h14, 7'h18,  // 0..3
    7'h21, 7'h22, 7'h24, 7'h28,  // 4..7
    7'h41, 7'h42, 7'h44, 7'h48,  // 8..11
    7'h03, 7'h06, 7'h0C, 7'h09   // 12..15
  };

  localparam logic [6:0] eop_2of7 = 7'h60;  // end of packet

  // --------------------------------------------------------------------------
  // sender fsm encoding
  // --------------------------------------------------------------------------
  localparam logic [1:0] st_idle = 2'd0;    // waiting for a packet
  localparam logic [1:0] st_tran = 2'd1;    // sending nibbles
  localparam logic [1:0] st_eop  = 2'd2;    // eop out, waiting for its ack

  // --------------------------------------------------------------------------
  // packet word
  // --------------------------------------------------------------------------
  // raw view for nibble shifting, field view for the control byte
  typedef union packed {
    logic [pkt_bits-1:0] raw;
    struct packed {
      logic [31:0] payload;                 // long packets only
      logic [31:0] key;                     // routing key
      logic [7:0]  ctrl;                    // control byte, bit 1 = long
    } f;
  } pkt_word_u;

endpackage

/* rtl/spinn_link_sender.sv */
// transmit endpoint: takes one packet per valid strobe and sends it as 2-of-7 symbols, ack paced
module spin_link_sender
(
  input  logic                                CLK_IN,
  input  logic                                RESET_IN,

  // synchronous packet side
  input  logic [spinn_link_pkg::pkt_bits-1:0] pkt_data_in,
  input  logic                                pkt_vld_in,
  output logic                                pkt_rdy_out,

  // self-timed link side
  output logic [6:0]                          sl_data_2of7_out,
  input  logic                                sl_ack_in,

  // one pulse per packet sent
  output logic                                count_packet_out
);

  import spinn_link_pkg::*;

  // --------------------------------------------------------------------------
  // internal signals
  // --------------------------------------------------------------------------
  logic [1:0] state;
  logic       old_ack;                      // ack level at last symbol sent
  logic       ack_seen;                     // far end toggled since then
  logic       long_pkt;                     // stored long flag
  logic [4:0] symbol_cnt;                   // nibbles sent so far
  logic       eop;                          // all nibbles gone, eop next
  logic [6:0] next_code;

  pkt_word_u  pkt_in;                       // field view of the input word
  pkt_word_u  pkt_buf;                      // shift buffer, low nibble next

  assign pkt_in = pkt_data_in;

  assign ack_seen = (old_ack != sl_ack_in);

  // last nibble count depends on packet size
  assign eop = (!long_pkt && (symbol_cnt == short_syms)) || (symbol_cnt == long_syms);

  // code to flip onto the wires when the next ack arrives
  assign next_code = eop ? eop_2of7 : code_2of7[pkt_buf.raw[3:0]];

  // --------------------------------------------------------------------------
  // control fsm, link wires and packet side
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      state            <= st_idle;
      sl_data_2of7_out <= 7'd0;
      old_ack          <= 1'b0;
      pkt_rdy_out      <= 1'b1;             // ready straight out of reset
      symbol_cnt       <= 5'd0;
      long_pkt         <= 1'b0;
      count_packet_out <= 1'b0;
    end
    else
    begin
      count_packet_out <= 1'b0;             // single cycle pulse
      case (state)
        st_idle:
        begin
          if (pkt_vld_in)
          begin
            // first nibble leaves right away
            sl_data_2of7_out <= sl_data_2of7_out ^ code_2of7[pkt_in.raw[3:0]];
            old_ack          <= sl_ack_in;
            pkt_rdy_out      <= 1'b0;
            symbol_cnt       <= 5'd1;
            long_pkt         <= pkt_in.f.ctrl[long_bit];
            state            <= st_tran;
          end
        end

        st_tran:
        begin
          if (ack_seen)
          begin
            sl_data_2of7_out <= sl_data_2of7_out ^ next_code;  // nibble or eop
            old_ack          <= sl_ack_in;
            symbol_cnt       <= symbol_cnt + 5'd1;
            if (eop)
            begin
              count_packet_out <= 1'b1;     // packet fully on the wires
              state            <= st_eop;
            end
          end
        end

        st_eop:
        begin
          if (ack_seen)
          begin
            old_ack     <= sl_ack_in;
            pkt_rdy_out <= 1'b1;            // eop acknowledged
            state       <= st_idle;
          end
        end

        default:
        begin
          state <= st_idle;                 // unused code, back to idle
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // packet shift buffer
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN)
  begin
    if ((state == st_idle) && pkt_vld_in)
      pkt_buf.raw <= pkt_in.raw >> 4;       // first nibble already sent
    else if ((state == st_tran) && ack_seen)
      pkt_buf.raw <= pkt_buf.raw >> 4;      // line up the next one
  end

endmodule

/* rtl/spinn_link_receiver.sv */
// receive endpoint: synchronizes the 2-of-7 wires, decodes symbols and assembles packets for the sink
module spinn_link_receiver
(
  input  logic                                CLK_IN,
  input  logic                                RESET_IN,

  // self-timed link side
  input  logic [6:0]                          sl_data_2of7_in,
  output logic                                sl_ack_out,

  // synchronous packet side
  output logic [spinn_link_pkg::pkt_bits-1:0] pkt_data_out,
  output logic                                pkt_vld_out,
  input  logic                                pkt_rdy_in,

  // one pulse per packet taken by the sink
  output logic                                count_packet_out
);

  import spinn_link_pkg::*;

  // --------------------------------------------------------------------------
  // internal signals
  // --------------------------------------------------------------------------
  logic [6:0] sync_q1;                      // first synchronizer stage
  logic [6:0] sync_q2;                      // second stage, safe to use
  logic [6:0] last_data;                    // wire state at last symbol taken
  logic [6:0] sym_diff;                     // wires flipped since then
  logic       sym_take;                     // complete symbol present
  logic       sym_eop;
  logic [3:0] sym_nib;
  logic [4:0] nib_cnt;                      // nibbles of this packet so far
  logic       pkt_taken;                    // sink accepts this cycle

  pkt_word_u  asm_buf;                      // packet under assembly
  pkt_word_u  done_pkt;                     // assembled word, unsent bits zero

  // --------------------------------------------------------------------------
  // input synchronizer
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      sync_q1 <= 7'd0;
      sync_q2 <= 7'd0;
    end
    else
    begin
      sync_q1 <= sl_data_2of7_in;
      sync_q2 <= sync_q1;
    end
  end

  // --------------------------------------------------------------------------
  // symbol detect and decode
  // --------------------------------------------------------------------------
  assign sym_diff = sync_q2 ^ last_data;

  // two wires flipped means the symbol is complete
  // nothing is taken while a finished packet waits for the sink
  assign sym_take = ($countones(sym_diff) == 2) && !pkt_vld_out;

  assign pkt_taken = pkt_vld_out && pkt_rdy_in;

  always_comb
  begin
    sym_eop = (sym_diff == eop_2of7);
    sym_nib = 4'd0;                         // unknown pair decodes as 0
    for (int i = 0; i < 16; i++)
      if (sym_diff == code_2of7[i])
        sym_nib = 4'(i);
  end

  // --------------------------------------------------------------------------
  // link and packet control
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      last_data        <= 7'd0;
      nib_cnt          <= 5'd0;
      sl_ack_out       <= 1'b0;
      pkt_vld_out      <= 1'b0;
      count_packet_out <= 1'b0;
    end
    else
    begin
      count_packet_out <= 1'b0;             // single cycle pulse
      if (sym_take)
      begin
        last_data <= sync_q2;               // new reference for next symbol
        if (sym_eop)
        begin
          pkt_vld_out <= 1'b1;              // ack held back until taken
          nib_cnt     <= 5'd0;
        end
        else
        begin
          sl_ack_out <= ~sl_ack_out;        // ask for the next nibble
          nib_cnt    <= nib_cnt + 5'd1;
        end
      end
      if (pkt_taken)
      begin
        pkt_vld_out      <= 1'b0;
        sl_ack_out       <= ~sl_ack_out;    // release the eop, link resumes
        count_packet_out <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // packet assembly
  // --------------------------------------------------------------------------
  // payload of a short packet never arrives, force it to zero
  always_comb
  begin
    done_pkt = asm_buf;
    if (!asm_buf.f.ctrl[long_bit])
      done_pkt.f.payload = 32'd0;
  end

  always_ff @(posedge CLK_IN)
  begin
    if (sym_take && !sym_eop)
      asm_buf.raw[{nib_cnt, 2'b00} +: 4] <= sym_nib;  // nibble n at bits 4n
    if (sym_take && sym_eop)
      pkt_data_out <= done_pkt.raw;         // held while vld is high
  end

endmodule

/* rtl/spinn_link_pkt_counter.sv */
// packet statistics: counts packets sent and received from the endpoints' count pulses
module spinn_link_pkt_counter
(
  input  logic                                  CLK_IN,
  input  logic                                  RESET_IN,

  // count pulses from the endpoints
  input  logic                                  tx_pulse,
  input  logic                                  rx_pulse,

  // running totals
  output logic [spinn_link_pkg::count_bits-1:0] tx_count,
  output logic [spinn_link_pkg::count_bits-1:0] rx_count
);

  // --------------------------------------------------------------------------
  // wrap-around counters
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN)
  begin
    if (RESET_IN)
    begin
      tx_count <= '0;
      rx_count <= '0;
    end
    else
    begin
      if (tx_pulse)
        tx_count <= tx_count + 1'b1;        // rolls over at full scale
      if (rx_pulse)
        rx_count <= rx_count + 1'b1;
    end
  end

endmodule

/* rtl/spinn_link_node.sv */
// link node top level: one transmit and one receive spinnaker link endpoint plus packet counters
module spinn_link_node
(
  input  logic                                  CLK_IN,
  input  logic                                  RESET_IN,

  // packets into the transmit endpoint
  input  logic [spinn_link_pkg::pkt_bits-1:0]   pkt_data_in,
  input  logic                                  pkt_vld_in,
  output logic                                  pkt_rdy_out,

  // packets out of the receive endpoint
  output logic [spinn_link_pkg::pkt_bits-1:0]   pkt_data_out,
  output logic                                  pkt_vld_out,
  input  logic                                  pkt_rdy_in,

  // transmit link
  output logic [6:0]                            tx_data_2of7_out,
  input  logic                                  tx_ack_in,

  // receive link
  input  logic [6:0]                            rx_data_2of7_in,
  output logic                                  rx_ack_out,

  // packet counts
  output logic [spinn_link_pkg::count_bits-1:0] tx_count_out,
  output logic [spinn_link_pkg::count_bits-1:0] rx_count_out
);

  logic tx_pulse;                           // packet left on the link
  logic rx_pulse;                           // packet taken by the sink

  // --------------------------------------------------------------------------
  // endpoints and counters
  // --------------------------------------------------------------------------
  spin_link_sender i_sender
  (
    .CLK_IN           (CLK_IN),
    .RESET_IN         (RESET_IN),
    .pkt_data_in      (pkt_data_in),
    .pkt_vld_in       (pkt_vld_in),
    .pkt_rdy_out      (pkt_rdy_out),
    .sl_data_2of7_out (tx_data_2of7_out),
    .sl_ack_in        (tx_ack_in),
    .count_packet_out (tx_pulse)
  );

  spinn_link_receiver i_receiver
  (
    .CLK_IN           (CLK_IN),
    .RESET_IN         (RESET_IN),
    .sl_data_2of7_in  (rx_data_2of7_in),
    .sl_ack_out       (rx_ack_out),
    .pkt_data_out     (pkt_data_out),
    .pkt_vld_out      (pkt_vld_out),
    .pkt_rdy_in       (pkt_rdy_in),
    .count_packet_out (rx_pulse)
  );

  spinn_link_pkt_counter i_counter
  (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .tx_pulse (tx_pulse),
    .rx_pulse (rx_pulse),
    .tx_count (tx_count_out),
    .rx_count (rx_count_out)
  );

endmodule

/* sim/spinn_link_chk.sv */
// assertion checker bound into the link node that watches link symbols and both packet handshakes
module spinn_link_chk
(
  input logic                                CLK_IN,
  input logic                                RESET_IN,
  input logic [6:0]                          tx_data_2of7_out,
  input logic                                pkt_vld_in,
  input logic                                pkt_rdy_out,
  input logic [spinn_link_pkg::pkt_bits-1:0] pkt_data_out,
  input logic                                pkt_vld_out,
  input logic                                pkt_rdy_in
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_fails = 0;            // failed assertions so far

  // --------------------------------------------------------------------------
  // link side
  // --------------------------------------------------------------------------
  // every nrz 2-of-7 symbol flips exactly two wires
  two_wire_flip: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    $changed(tx_data_2of7_out) |->
      ($countones(tx_data_2of7_out ^ $past(tx_data_2of7_out)) == 2))
  else
  begin
    $error("tx link changed in other than two wires");
    assert_fails++;
  end

  // wires only move while a packet is in flight
  rdy_low_sending: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    $changed(tx_data_2of7_out) |-> !pkt_rdy_out)
  else
  begin
    $error("pkt_rdy_out high while symbols are being sent");
    assert_fails++;
  end

  // --------------------------------------------------------------------------
  // packet sides
  // --------------------------------------------------------------------------
  rdy_low_on_take: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (pkt_vld_in && pkt_rdy_out) |=> !pkt_rdy_out)
  else
  begin
    $error("pkt_rdy_out did not fall after a packet was taken");
    assert_fails++;
  end

  out_hold: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (pkt_vld_out && !pkt_rdy_in) |=> (pkt_vld_out && $stable(pkt_data_out)))
  else
  begin
    $error("output packet changed or dropped while stalled");
    assert_fails++;
  end

endmodule

bind spinn_link_node spinn_link_chk i_chk
(
  .CLK_IN           (CLK_IN),
  .RESET_IN         (RESET_IN),
  .tx_data_2of7_out (tx_data_2of7_out),
  .pkt_vld_in       (pkt_vld_in),
  .pkt_rdy_out      (pkt_rdy_out),
  .pkt_data_out     (pkt_data_out),
  .pkt_vld_out      (pkt_vld_out),
  .pkt_rdy_in       (pkt_rdy_in)
);

/* sim/spinn_link_tb.sv */
// top-level loopback testbench for the link node that sends a table of packets through tx into rx
module spinn_link_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import spinn_link_pkg::*;

  localparam int num_tests      = 12;
  localparam int timeout_cycles = num_tests * 400;  // generous per packet budget

  // --------------------------------------------------------------------------
  // dut signals
  // --------------------------------------------------------------------------
  logic                  CLK_IN;
  logic                  RESET_IN;
  logic [pkt_bits-1:0]   pkt_data_in;
  logic                  pkt_vld_in;
  logic                  pkt_rdy_out;
  logic [pkt_bits-1:0]   pkt_data_out;
  logic                  pkt_vld_out;
  logic                  pkt_rdy_in;
  logic [6:0]            tx_data_2of7_out;
  logic                  tx_ack_in;
  logic [6:0]            rx_data_2of7_in;
  logic                  rx_ack_out;
  logic [count_bits-1:0] tx_count_out;
  logic [count_bits-1:0] rx_count_out;

  // stimulus table of packet, stall cycles and expected output word
  logic [pkt_bits-1:0]   pkt_tab   [num_tests];
  int                    stall_tab [num_tests];
  logic [pkt_bits-1:0]   exp_tab   [num_tests];

  int seed;
  int cycle_cnt   = 0;
  int accepted    = 0;                      // packets taken from the dut
  int data_errs   = 0;
  int count_errs  = 0;
  int hs_errs     = 0;                      // handshake and protocol
  int assert_errs = 0;

  spinn_link_node i_spinn_link_node
  (
    .CLK_IN           (CLK_IN),
    .RESET_IN         (RESET_IN),
    .pkt_data_in      (pkt_data_in),
    .pkt_vld_in       (pkt_vld_in),
    .pkt_rdy_out      (pkt_rdy_out),
    .pkt_data_out     (pkt_data_out),
    .pkt_vld_out      (pkt_vld_out),
    .pkt_rdy_in       (pkt_rdy_in),
    .tx_data_2of7_out (tx_data_2of7_out),
    .tx_ack_in        (tx_ack_in),
    .rx_data_2of7_in  (rx_data_2of7_in),
    .rx_ack_out       (rx_ack_out),
    .tx_count_out     (tx_count_out),
    .rx_count_out     (rx_count_out)
  );

  // tx wires looped into rx and rx ack back into tx
  assign rx_data_2of7_in = tx_data_2of7_out;
  assign tx_ack_in       = rx_ack_out;

  always #50 CLK_IN = ~CLK_IN;              // 100 ns period

  // --------------------------------------------------------------------------
  // watchdog
  // --------------------------------------------------------------------------
  always @(posedge CLK_IN)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("timeout after %0d cycles, the link stopped making progress", cycle_cnt);
      $display("errors: data %0d, count %0d, handshake %0d", data_errs, count_errs, hs_errs);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic next_cycle;
    @(posedge CLK_IN);
    #10;                                    // drive and sample point
  endtask

  // short packets (ctrl bit 1 clear) come out with the payload zeroed
  task automatic load_table;
    pkt_tab[0]  = 72'h01234567_89ABCDEF_00;
    exp_tab[0]  = 72'h00000000_89ABCDEF_00;
    pkt_tab[1]  = 72'hDEADBEEF_CAFEF00D_02;
    exp_tab[1]  = 72'hDEADBEEF_CAFEF00D_02;
    pkt_tab[2]  = 72'hFFFFFFFF_00000000_01;
    exp_tab[2]  = 72'h00000000_00000000_01;
    pkt_tab[3]  = 72'h00000000_FFFFFFFF_03;
    exp_tab[3]  = 72'h00000000_FFFFFFFF_03;
    pkt_tab[4]  = 72'hA5A5A5A5_5A5A5A5A_80;
    exp_tab[4]  = 72'h00000000_5A5A5A5A_80;
    pkt_tab[5]  = 72'h12345678_9ABCDEF0_FF;
    exp_tab[5]  = 72'h12345678_9ABCDEF0_FF;
    pkt_tab[6]  = 72'h87654321_0FEDCBA9_FD;
    exp_tab[6]  = 72'h00000000_0FEDCBA9_FD;
    pkt_tab[7]  = 72'h11111111_22222222_42;
    exp_tab[7]  = 72'h11111111_22222222_42;
    pkt_tab[8]  = 72'hFEDCBA98_76543210_00;
    exp_tab[8]  = 72'h00000000_76543210_00;
    pkt_tab[9]  = 72'h0F0F0F0F_F0F0F0F0_06;
    exp_tab[9]  = 72'h0F0F0F0F_F0F0F0F0_06;
    pkt_tab[10] = 72'hCCCCCCCC_33333333_44;
    exp_tab[10] = 72'h00000000_33333333_44;
    pkt_tab[11] = 72'h55555555_AAAAAAAA_0E;
    exp_tab[11] = 72'h55555555_AAAAAAAA_0E;
    stall_tab   = '{0, 3, 7, 1, 12, 2, 5, 0, 0, 0, 0, 0};  // last five back to back
  endtask

  task automatic check_data(input int idx);
    if (pkt_data_out !== exp_tab[idx])
    begin
      $display("error at %0t ns: pkt_data_out = %h, expected %h (entry %0d)",
               $time, pkt_data_out, exp_tab[idx], idx);
      data_errs++;
    end
  endtask

  // counter updates two edges after the sink takes the packet
  task automatic wait_rx_count(input int n);
    int k;
    k = 0;
    while ((rx_count_out !== n) && (k < 4))
    begin
      next_cycle();
      k++;
    end
    if (rx_count_out !== n)
    begin
      $display("error at %0t ns: rx_count_out = %0d, expected %0d", $time, rx_count_out, n);
      count_errs++;
    end
  endtask

  // --------------------------------------------------------------------------
  // one table entry sent, stalled at the sink, checked and accepted
  // --------------------------------------------------------------------------
  task automatic run_entry(input int idx);
    int stall;
    while (!pkt_rdy_out)
      next_cycle();
    pkt_data_in = pkt_tab[idx];
    pkt_vld_in  = 1'b1;
    next_cycle();                           // taken at this edge
    pkt_vld_in  = 1'b0;
    if (pkt_rdy_out)
    begin
      $display("pkt_rdy_out stayed high after entry %0d was handed over", idx);
      hs_errs++;
    end
    while (!pkt_vld_out)
      next_cycle();
    check_data(idx);
    stall = stall_tab[idx];
    if (stall != 0)
      stall = stall + ($unsigned($random(seed)) % 3);  // jitter the stall a bit
    repeat (stall)
    begin
      next_cycle();
      if (!pkt_vld_out)
      begin
        $display("pkt_vld_out dropped during a stall on entry %0d", idx);
        hs_errs++;
      end
      check_data(idx);                      // must hold while stalled
    end
    pkt_rdy_in = 1'b1;
    next_cycle();                           // sink takes it here
    pkt_rdy_in = 1'b0;
    accepted++;
    if (pkt_vld_out)
    begin
      $display("pkt_vld_out still high after entry %0d was taken", idx);
      hs_errs++;
    end
    wait_rx_count(accepted);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    int total;
    seed        = 58;
    CLK_IN      = 1'b0;
    RESET_IN    = 1'b1;
    pkt_data_in = '0;
    pkt_vld_in  = 1'b0;
    pkt_rdy_in  = 1'b0;                     // sink starts stalled
    load_table();
    repeat (2) @(posedge CLK_IN);
    #10;
    RESET_IN = 1'b0;

    // state straight after reset
    if (pkt_rdy_out !== 1'b1)
    begin
      $display("error at %0t ns: pkt_rdy_out = %b, expected 1", $time, pkt_rdy_out);
      hs_errs++;
    end
    if (pkt_vld_out !== 1'b0)
    begin
      $display("error at %0t ns: pkt_vld_out = %b, expected 0", $time, pkt_vld_out);
      hs_errs++;
    end
    if (tx_data_2of7_out !== 7'd0)
    begin
      $display("error at %0t ns: tx_data_2of7_out = %h, expected 0", $time, tx_data_2of7_out);
      hs_errs++;
    end
    if (rx_ack_out !== 1'b0)
    begin
      $display("error at %0t ns: rx_ack_out = %b, expected 0", $time, rx_ack_out);
      hs_errs++;
    end
    if ((tx_count_out !== '0) || (rx_count_out !== '0))
    begin
      $display("error at %0t ns: tx_count_out = %0d, rx_count_out = %0d, expected 0 and 0",
               $time, tx_count_out, rx_count_out);
      count_errs++;
    end

    for (int i = 0; i < num_tests; i++)
      run_entry(i);

    if (tx_count_out !== num_tests)
    begin
      $display("error at %0t ns: tx_count_out = %0d, expected %0d",
               $time, tx_count_out, num_tests);
      count_errs++;
    end

    assert_errs = i_spinn_link_node.i_chk.assert_fails;
    total       = data_errs + count_errs + hs_errs + assert_errs;
    $display("errors: data %0d, count %0d, handshake %0d, assertion %0d",
             data_errs, count_errs, hs_errs, assert_errs);
    if (total == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/spinn_link_pkg.sv
rtl/spinn_link_sender.sv
rtl/spinn_link_receiver.sv
rtl/spinn_link_pkt_counter.sv
rtl/spinn_link_node.sv
sim/spinn_link_chk.sv
sim/spinn_link_tb.sv
